/* Bender.yml */
package:
  name: rv_exec

sources:
  - rv_pkg.sv
  - rv_apb_regs.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_result.sv
  - rv_exec_top.sv
  - target: test
    files:
      - rv_exec_checker.sv
      - tb_rv_exec.sv

/* rv_apb_regs.sv */
`timescale 1ns/1ps

module rv_apb_regs import rv_pkg::*; (
    input  logic              CLK,
    input  logic              RST,
    input  apb_req_t          apb_req_i,
    output apb_rsp_t          apb_rsp_o,
    input  logic              busy_i,
    input  logic [XLEN-1:0]   next_pc_i,
    input  logic [XLEN-1:0]   status_i,
    output logic [REG_AW-1:0] reg_raddr_o,
    input  logic [XLEN-1:0]   reg_rdata_i,
    output issue_t            issue_o
);

    logic            access;
    logic            is_pc;
    logic            is_inst;
    logic            is_npc;
    logic            is_stat;
    logic            is_reg;
    logic            is_ro;
    logic            err;
    logic            slow;
    logic            pipe_busy;
    logic            done;
    logic            wr_ok;
    logic            dec_busy_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] status_rd;
    logic [XLEN-1:0] rdata;
    issue_t          issue_q;

    assign access  = apb_req_i.psel & apb_req_i.penable;
    assign is_pc   = (apb_req_i.paddr == ADDR_PC);
    assign is_inst = (apb_req_i.paddr == ADDR_INST);
    assign is_npc  = (apb_req_i.paddr == ADDR_NEXT_PC);
    assign is_stat = (apb_req_i.paddr == ADDR_STATUS);
    assign is_reg  = (apb_req_i.paddr >= REG_BASE) && (apb_req_i.paddr[1:0] == 2'b00);
    assign is_ro   = is_npc | is_stat | is_reg;

    assign err = ~(is_pc | is_inst | is_ro)
               | (apb_req_i.pwrite & is_ro)
               | (~apb_req_i.pwrite & is_inst);

    // reads of pipeline results wait until the last instruction retires
    assign slow      = ~apb_req_i.pwrite & is_ro;
    assign pipe_busy = issue_q.valid | dec_busy_q | busy_i;
    assign done      = access & ~(slow & pipe_busy);
    assign wr_ok     = done & ~err & apb_req_i.pwrite;

    assign reg_raddr_o = apb_req_i.paddr[REG_AW+1:2];

    always_comb begin
        status_rd = status_i;
        status_rd[STAT_BUSY] = pipe_busy;
        if (is_pc) begin
            rdata = pc_q;
        end else if (is_npc) begin
            rdata = next_pc_i;
        end else if (is_stat) begin
            rdata = status_rd;
        end else if (is_reg) begin
            rdata = reg_rdata_i;
        end else begin
            rdata = '0;
        end
    end

    assign apb_rsp_o.pready  = done;
    assign apb_rsp_o.pslverr = done & err;
    assign apb_rsp_o.prdata  = err ? '0 : rdata;

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc_q          <= '0;
            issue_q.valid <= 1'b0;
            dec_busy_q    <= 1'b0;
        end else begin
            issue_q.valid <= wr_ok & is_inst;
            dec_busy_q    <= issue_q.valid;
            if (wr_ok && is_pc) begin
                pc_q <= apb_req_i.pwdata;
            end
        end
        if (wr_ok && is_inst) begin
            issue_q.pc   <= pc_q;
            issue_q.inst <= apb_req_i.pwdata;
        end
    end

    assign issue_o = issue_q;

endmodule

/* rv_decode.sv */
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
    input  logic              CLK,
    input  logic              RST,
    input  issue_t            issue_i,
    output logic [REG_AW-1:0] rs1_addr_o,
    output logic [REG_AW-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]   rs1_data_i,
    input  logic [XLEN-1:0]   rs2_data_i,
    input  fwd_t              ex_fwd_i,
    input  fwd_t              res_fwd_i,
    output dec_t              dec_o
);

    inst_u           inst;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm;
    logic [1:0]      src_a;
    logic [1:0]      src_b;
    dec_t            dec_d;
    dec_t            dec_q;

    // execute result wins over writeback, x0 never forwards
    function automatic logic [XLEN-1:0] operand(
        input logic [1:0]        src,
        input logic [REG_AW-1:0] ra,
        input logic [XLEN-1:0]   rf_data,
        input logic [XLEN-1:0]   imm_val,
        input logic [XLEN-1:0]   pc,
        input fwd_t              ex,
        input fwd_t              res
    );
        case (src)
            SRC_ZERO: operand = '0;
            SRC_IMM:  operand = imm_val;
            SRC_PC:   operand = pc;
            default: begin
                if (ex.we && ex.rd == ra && ra != ZERO_REG) begin
                    operand = ex.data;
                end else if (res.we && res.rd == ra && ra != ZERO_REG) begin
                    operand = res.data;
                end else begin
                    operand = rf_data;
                end
            end
        endcase
    endfunction

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        arith_op = ALU_NOP;
        case (f3)
            F3_ADD:  arith_op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  arith_op = ALU_SLL;
            F3_SLT:  arith_op = ALU_SLT;
            F3_SLTU: arith_op = ALU_SLTU;
            F3_XOR:  arith_op = ALU_XOR;
            F3_SR:   arith_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   arith_op = ALU_OR;
            F3_AND:  arith_op = ALU_AND;
        endcase
    endfunction

    assign inst  = issue_i.inst;
    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_b = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign imm_u = {inst.u.imm, 12'b0};
    assign imm_j = {{12{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11, inst.j.imm10_1, 1'b0};

    assign rs1_addr_o = inst.r.rs1;
    assign rs2_addr_o = inst.r.rs2;

    always_comb begin
        dec_d       = '0;
        dec_d.valid = issue_i.valid;
        dec_d.rd    = inst.r.rd;
        dec_d.link  = issue_i.pc + 32'd4;
        src_a       = SRC_ZERO;
        src_b       = SRC_ZERO;
        imm         = '0;
        case (inst.r.opcode)
            OP_LUI: begin
                dec_d.alu_op = ALU_LUI;
                dec_d.we     = 1'b1;
                src_b        = SRC_IMM;
                imm          = imm_u;
            end
            OP_AUIPC: begin
                dec_d.alu_op = ALU_AUIPC;
                dec_d.we     = 1'b1;
                src_a        = SRC_PC;
                src_b        = SRC_IMM;
                imm          = imm_u;
            end
            OP_JAL: begin
                dec_d.alu_op = ALU_JMP;
                dec_d.we     = 1'b1;
                dec_d.target = issue_i.pc + imm_j;
            end
            OP_JALR: begin
                // execute adds rs1 to this offset
                dec_d.alu_op = ALU_JMP;
                dec_d.we     = 1'b1;
                dec_d.target = imm_i;
                src_a        = SRC_REG;
            end
            OP_BRANCH: begin
                dec_d.target = issue_i.pc + imm_b;
                src_a        = SRC_REG;
                src_b        = SRC_REG;
                case (inst.b.funct3)
                    F3_BEQ:  dec_d.alu_op = ALU_BEQ;
                    F3_BNE:  dec_d.alu_op = ALU_BNE;
                    F3_BLT:  dec_d.alu_op = ALU_BLT;
                    F3_BGE:  dec_d.alu_op = ALU_BGE;
                    F3_BLTU: dec_d.alu_op = ALU_BLTU;
                    F3_BGEU: dec_d.alu_op = ALU_BGEU;
                    default: dec_d.illegal = 1'b1;
                endcase
            end
            OP_OP_IMM: begin
                dec_d.alu_op = arith_op(inst.i.funct3,
                                        inst.i.funct3 == F3_SR && inst.r.funct7 == F7_ALT);
                dec_d.we     = 1'b1;
                src_a        = SRC_REG;
                src_b        = SRC_IMM;
                imm          = imm_i;
            end
            OP_OP: begin
                src_a = SRC_REG;
                src_b = SRC_REG;
                if (inst.r.funct7 == F7_BASE || inst.r.funct7 == F7_ALT) begin
                    dec_d.alu_op = arith_op(inst.r.funct3, inst.r.funct7 == F7_ALT);
                    dec_d.we     = 1'b1;
                end else begin
                    dec_d.illegal = 1'b1;
                end
            end
            default: begin
                dec_d.illegal = 1'b1;
            end
        endcase
        dec_d.op_a = operand(src_a, inst.r.rs1, rs1_data_i, imm, issue_i.pc,
                             ex_fwd_i, res_fwd_i);
        dec_d.op_b = operand(src_b, inst.r.rs2, rs2_data_i, imm, issue_i.pc,
                             ex_fwd_i, res_fwd_i);
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            dec_q.valid <= 1'b0;
        end else begin
            dec_q.valid <= dec_d.valid;
        end
        dec_q.alu_op  <= dec_d.alu_op;
        dec_q.op_a    <= dec_d.op_a;
        dec_q.op_b    <= dec_d.op_b;
        dec_q.rd      <= dec_d.rd;
        dec_q.we      <= dec_d.we;
        dec_q.link    <= dec_d.link;
        dec_q.target  <= dec_d.target;
        dec_q.illegal <= dec_d.illegal;
    end

    assign dec_o = dec_q;

endmodule

/* rv_exec_checker.sv */
`timescale 1ns/1ps

module rv_exec_checker import rv_pkg::*; (
    input logic     CLK,
    input logic     RST,
    input apb_req_t apb_req_i,
    input apb_rsp_t apb_rsp_i,
    input issue_t   issue_i
);

    int unsigned fail_count = 0;

    a_ready_in_access: assert property (@(posedge CLK) disable iff (RST)
        apb_rsp_i.pready |-> apb_req_i.psel && apb_req_i.penable)
        else begin
            fail_count++;
            $error("pready high outside an APB access phase");
        end

    a_slverr_with_ready: assert property (@(posedge CLK) disable iff (RST)
        apb_rsp_i.pslverr |-> apb_rsp_i.pready)
        else begin
            fail_count++;
            $error("pslverr raised without pready");
        end

    // x0 is hardwired to zero
    a_x0_reads_zero: assert property (@(posedge CLK) disable iff (RST)
        (apb_rsp_i.pready && !apb_req_i.pwrite && apb_req_i.paddr == REG_BASE)
        |-> apb_rsp_i.prdata == '0)
        else begin
            fail_count++;
            $error("read of x0 returned nonzero data");
        end

    a_issue_one_cycle: assert property (@(posedge CLK) disable iff (RST)
        issue_i.valid |=> !issue_i.valid)
        else begin
            fail_count++;
            $error("issue valid held for more than one cycle");
        end

endmodule

bind rv_exec_top rv_exec_checker rv_exec_checker_i (
    .CLK       (CLK),
    .RST       (RST),
    .apb_req_i (apb_req_i),
    .apb_rsp_i (apb_rsp_o),
    .issue_i   (issue)
);

/* rv_exec_golden.txt */
// kind_addr_data_err: kind 0 write, 1 read, 2 write and 3 read expecting pslverr, f ends
// data is the write data or the expected read data, err is the expected pslverr bit
// state after reset
1_0C_00000000_0
1_08_00000000_0
1_00_00000000_0
// alu chain at pc 0x100: lui, addi, srai, sub, sltu, slt, sll, srl, xor, and, or, add, auipc
0_00_00000100_0
0_04_800000B7_0
0_04_12308113_0
0_04_40415193_0
0_04_40218233_0
0_04_003232B3_0
0_04_0051A333_0
0_04_006213B3_0
0_04_0063D433_0
0_04_002444B3_0
0_04_0034F533_0
0_04_002565B3_0
0_04_00B58633_0
0_04_00001697_0
1_84_80000000_0
1_88_80000123_0
1_8C_F8000012_0
1_90_77FFFEEF_0
1_94_00000001_0
1_98_00000001_0
1_9C_EFFFFDDE_0
1_A0_77FFFEEF_0
1_A4_F7FFFFCC_0
1_A8_F0000000_0
1_AC_F0000123_0
1_B0_E0000246_0
1_B4_00001100_0
// branches at pc 0x200, each taken then not taken: beq, bne, blt, bge, bltu, bgeu
0_00_00000200_0
0_04_00628863_0
1_08_00000210_0
1_0C_00000001_0
0_04_00328863_0
1_08_00000204_0
1_0C_00000000_0
0_04_FE329CE3_0
1_08_000001F8_0
1_0C_00000001_0
0_04_FE629CE3_0
1_08_00000204_0
1_0C_00000000_0
0_04_0051C0E3_0
1_08_00000A00_0
1_0C_00000001_0
0_04_0032C0E3_0
1_08_00000204_0
1_0C_00000000_0
0_04_0032D863_0
1_08_00000210_0
1_0C_00000001_0
0_04_0051D863_0
1_08_00000204_0
1_0C_00000000_0
0_04_FE32ECE3_0
1_08_000001F8_0
1_0C_00000001_0
0_04_FE51ECE3_0
1_08_00000204_0
1_0C_00000000_0
0_04_0051F0E3_0
1_08_00000A00_0
1_0C_00000001_0
0_04_0032F0E3_0
1_08_00000204_0
1_0C_00000000_0
1_B4_00001100_0
1_94_00000001_0
// jumps at pc 0x300: jal x14, jal x0, jalr x15, jalr x16
0_00_00000300_0
0_04_1000076F_0
1_08_00000400_0
1_B8_00000304_0
0_04_FF1FF06F_0
1_08_000002F0_0
1_80_00000000_0
0_04_007687E7_0
1_08_00001106_0
0_04_FFD78867_0
1_08_00000300_0
1_BC_00000304_0
1_C0_00000304_0
1_0C_00000001_0
// undefined opcode with rd x1, then addi x17
0_04_0000008B_0
1_0C_00000002_0
0_04_00500893_0
1_0C_00000002_0
1_84_80000000_0
1_C4_00000005_0
// bus errors leave all state alone
3_10_00000000_1
2_40_12345678_1
2_08_DEADBEEF_1
2_0C_FFFFFFFF_1
2_94_0BADF00D_1
3_04_00000000_1
3_81_00000000_1
1_08_00000304_0
1_0C_00000002_0
1_94_00000001_0
1_00_00000300_0
F_00_00000000_0

/* rv_exec_top.sv */
`timescale 1ns/1ps

module rv_exec_top import rv_pkg::*; (
    input  logic     CLK,
    input  logic     RST,
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o
);

    issue_t            issue;
    dec_t              dec;
    exe_t              exe;
    fwd_t              ex_fwd;
    fwd_t              res_fwd;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [REG_AW-1:0] reg_raddr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   reg_rdata;
    logic [XLEN-1:0]   next_pc;
    logic [XLEN-1:0]   status;
    logic              busy;

    rv_apb_regs rv_apb_regs_i (
        .CLK         (CLK),
        .RST         (RST),
        .apb_req_i   (apb_req_i),
        .apb_rsp_o   (apb_rsp_o),
        .busy_i      (busy),
        .next_pc_i   (next_pc),
        .status_i    (status),
        .reg_raddr_o (reg_raddr),
        .reg_rdata_i (reg_rdata),
        .issue_o     (issue)
    );

    rv_decode rv_decode_i (
        .CLK        (CLK),
        .RST        (RST),
        .issue_i    (issue),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ex_fwd_i   (ex_fwd),
        .res_fwd_i  (res_fwd),
        .dec_o      (dec)
    );

    rv_execute rv_execute_i (
        .CLK      (CLK),
        .RST      (RST),
        .dec_i    (dec),
        .ex_fwd_o (ex_fwd),
        .exe_o    (exe)
    );

    rv_result rv_result_i (
        .CLK         (CLK),
        .RST         (RST),
        .exe_i       (exe),
        .rs1_addr_i  (rs1_addr),
        .rs2_addr_i  (rs2_addr),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .apb_raddr_i (reg_raddr),
        .apb_rdata_o (reg_rdata),
        .res_fwd_o   (res_fwd),
        .next_pc_o   (next_pc),
        .status_o    (status),
        .busy_o      (busy)
    );

endmodule

/* rv_execute.sv */
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
    input  logic CLK,
    input  logic RST,
    input  dec_t dec_i,
    output fwd_t ex_fwd_o,
    output exe_t exe_o
);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] jump_sum;
    logic [XLEN-1:0] target;
    logic            taken;
    exe_t            exe_q;

    assign a = dec_i.op_a;
    assign b = dec_i.op_b;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (dec_i.alu_op)
            ALU_ADD, ALU_AUIPC: result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << b[4:0];
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            ALU_SRL:  result = a >> b[4:0];
            ALU_SRA:  result = $signed(a) >>> b[4:0];
            ALU_LUI:  result = b;
            ALU_JMP: begin
                result = dec_i.link;
                taken  = 1'b1;
            end
            ALU_BEQ:  taken = (a == b);
            ALU_BNE:  taken = (a != b);
            ALU_BLT:  taken = ($signed(a) < $signed(b));
            ALU_BGE:  taken = ($signed(a) >= $signed(b));
            ALU_BLTU: taken = (a < b);
            ALU_BGEU: taken = (a >= b);
            default:  result = '0;
        endcase
    end

    // op_a is zero for jal, rs1 for jalr
    assign jump_sum = a + dec_i.target;
    assign target   = (dec_i.alu_op == ALU_JMP) ? {jump_sum[XLEN-1:1], 1'b0} : dec_i.target;

    assign ex_fwd_o.we   = dec_i.valid & dec_i.we;
    assign ex_fwd_o.rd   = dec_i.rd;
    assign ex_fwd_o.data = result;

    always_ff @(posedge CLK) begin
        if (RST) begin
            exe_q.valid <= 1'b0;
        end else begin
            exe_q.valid <= dec_i.valid;
        end
        exe_q.rd      <= dec_i.rd;
        exe_q.we      <= dec_i.we;
        exe_q.wdata   <= result;
        exe_q.taken   <= taken;
        exe_q.next_pc <= taken ? target : dec_i.link;
        exe_q.illegal <= dec_i.illegal;
    end

    assign exe_o = exe_q;

endmodule

/* rv_pkg.sv */
package rv_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int APB_AW = 8;

    localparam logic [REG_AW-1:0] ZERO_REG = 5'd0;

    // major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;

    // operand sources
    localparam logic [1:0] SRC_ZERO = 2'd0;
    localparam logic [1:0] SRC_REG  = 2'd1;
    localparam logic [1:0] SRC_IMM  = 2'd2;
    localparam logic [1:0] SRC_PC   = 2'd3;

    localparam logic [APB_AW-1:0] ADDR_PC      = 8'h00;
    localparam logic [APB_AW-1:0] ADDR_INST    = 8'h04;
    localparam logic [APB_AW-1:0] ADDR_NEXT_PC = 8'h08;
    localparam logic [APB_AW-1:0] ADDR_STATUS  = 8'h0C;
    localparam logic [APB_AW-1:0] REG_BASE     = 8'h80;

    localparam int STAT_TAKEN   = 0;
    localparam int STAT_ILLEGAL = 1;
    localparam int STAT_BUSY    = 2;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
        ALU_AND, ALU_SRL, ALU_SRA, ALU_LUI, ALU_AUIPC, ALU_JMP, ALU_BEQ, ALU_BNE,
        ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // imm bits sit where rd is in the other formats
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef struct packed {
        logic [APB_AW-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [XLEN-1:0]   pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        inst_u           inst;
    } issue_t;

    typedef struct packed {
        logic              valid;
        alu_op_e           alu_op;
        logic [XLEN-1:0]   op_a;
        logic [XLEN-1:0]   op_b;
        logic [REG_AW-1:0] rd;
        logic              we;
        logic [XLEN-1:0]   link;
        logic [XLEN-1:0]   target;
        logic              illegal;
    } dec_t;

    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic              we;
        logic [XLEN-1:0]   wdata;
        logic              taken;
        logic [XLEN-1:0]   next_pc;
        logic              illegal;
    } exe_t;

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } fwd_t;

endpackage

/* rv_result.sv */
`timescale 1ns/1ps

module rv_result import rv_pkg::*; (
    input  logic              CLK,
    input  logic              RST,
    input  exe_t              exe_i,
    input  logic [REG_AW-1:0] rs1_addr_i,
    input  logic [REG_AW-1:0] rs2_addr_i,
    output logic [XLEN-1:0]   rs1_data_o,
    output logic [XLEN-1:0]   rs2_data_o,
    input  logic [REG_AW-1:0] apb_raddr_i,
    output logic [XLEN-1:0]   apb_rdata_o,
    output fwd_t              res_fwd_o,
    output logic [XLEN-1:0]   next_pc_o,
    output logic [XLEN-1:0]   status_o,
    output logic              busy_o
);

    logic [XLEN-1:0] rf [1:31];
    logic [XLEN-1:0] next_pc_q;
    logic            taken_q;
    logic            illegal_q;
    logic            wr_en;

    assign wr_en = exe_i.valid & exe_i.we & (exe_i.rd != ZERO_REG);

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < 32; i++) begin
                rf[i] <= '0;
            end
            next_pc_q <= '0;
            taken_q   <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            if (wr_en) begin
                rf[exe_i.rd] <= exe_i.wdata;
            end
            if (exe_i.valid) begin
                next_pc_q <= exe_i.next_pc;
                taken_q   <= exe_i.taken;
                // sticky until reset
                illegal_q <= illegal_q | exe_i.illegal;
            end
        end
    end

    // x0 reads as zero on every port
    assign rs1_data_o  = (rs1_addr_i == ZERO_REG) ? '0 : rf[rs1_addr_i];
    assign rs2_data_o  = (rs2_addr_i == ZERO_REG) ? '0 : rf[rs2_addr_i];
    assign apb_rdata_o = (apb_raddr_i == ZERO_REG) ? '0 : rf[apb_raddr_i];

    assign res_fwd_o.we   = exe_i.valid & exe_i.we;
    assign res_fwd_o.rd   = exe_i.rd;
    assign res_fwd_o.data = exe_i.wdata;

    always_comb begin
        status_o               = '0;
        status_o[STAT_TAKEN]   = taken_q;
        status_o[STAT_ILLEGAL] = illegal_q;
    end

    assign next_pc_o = next_pc_q;

    // an instruction sitting here has not written back yet
    assign busy_o = exe_i.valid;

endmodule

/* tb_rv_exec.sv */
`timescale 1ns/1ps

module tb_rv_exec import rv_pkg::*; ();

    logic        CLK;
    logic        RST;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    // kind [47:44], address [43:36], data [35:4], expected pslverr [0]
    logic [47:0] golden [0:127];

    rv_exec_top rv_exec_top_i (
        .CLK       (CLK),
        .RST       (RST),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp)
    );

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "run aborted on the first error");
    endtask

    // a bound assertion failure ends the run right away
    always @(negedge CLK) begin
        if (rv_exec_top_i.rv_exec_checker_i.fail_count != 0) begin
            $display("a bound assertion on the APB or issue behaviour failed");
            abort_run();
        end
    end

    task automatic compare_rdata(input logic [APB_AW-1:0] addr, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Error prdata at 0x%02h: got 0x%08h, expected 0x%08h", addr, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_status(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Error status: got 0x%08h, expected 0x%08h", got, exp);
            abort_run();
        end
    endtask

    task automatic compare_slverr(input logic [APB_AW-1:0] addr, input logic got,
                                  input logic exp);
        if (got !== exp) begin
            $display("Error pslverr at 0x%02h: got 0x%0h, expected 0x%0h", addr, got, exp);
            abort_run();
        end
    endtask

    // starts and ends on a rising edge, so transfers run back to back
    task automatic apb_transfer(input logic write, input logic [APB_AW-1:0] addr,
                                input logic [XLEN-1:0] wdata,
                                output logic [XLEN-1:0] rdata, output logic slverr);
        int   waited;
        logic seen;
        apb_req.paddr   <= addr;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.pwdata  <= wdata;
        @(posedge CLK);
        apb_req.penable <= 1'b1;
        waited = 0;
        seen   = 1'b0;
        rdata  = '0;
        slverr = 1'b0;
        while (!seen) begin
            // response is settled mid-cycle and holds until the completing edge
            @(negedge CLK);
            if (apb_rsp.pready) begin
                seen   = 1'b1;
                rdata  = apb_rsp.prdata;
                slverr = apb_rsp.pslverr;
            end else if (waited == 64) begin
                $display("timeout: pready stayed low for 64 cycles at address 0x%02h", addr);
                abort_run();
            end else begin
                waited++;
            end
        end
        @(posedge CLK);
    endtask

    // register file comes out of reset all zero
    task automatic check_reset_regs();
        logic [APB_AW-1:0] addr;
        logic [XLEN-1:0]   rdata;
        logic              slverr;
        for (int r = 0; r < 32; r++) begin
            addr = REG_BASE + {1'b0, r[4:0], 2'b00};
            apb_transfer(1'b0, addr, '0, rdata, slverr);
            compare_slverr(addr, slverr, 1'b0);
            compare_rdata(addr, rdata, '0);
        end
    endtask

    task automatic play_golden();
        logic [3:0]        kind;
        logic [APB_AW-1:0] addr;
        logic [XLEN-1:0]   data;
        logic              exp_err;
        logic [XLEN-1:0]   rdata;
        logic              slverr;
        int                idx;
        idx = 0;
        while (idx < 128 && golden[idx][47:44] != 4'hF) begin
            kind    = golden[idx][47:44];
            addr    = golden[idx][43:36];
            data    = golden[idx][35:4];
            exp_err = golden[idx][0];
            if (kind > 4'd3) begin
                $display("golden entry %0d has an unknown access kind %0h", idx, kind);
                abort_run();
            end
            // even kinds write, odd kinds read
            apb_transfer(~kind[0], addr, data, rdata, slverr);
            compare_slverr(addr, slverr, exp_err);
            if (kind == 4'd1) begin
                if (addr == ADDR_STATUS) begin
                    compare_status(rdata, data);
                end else begin
                    compare_rdata(addr, rdata, data);
                end
            end
            idx++;
        end
    endtask

    initial begin
        RST     = 1'b1;
        apb_req = '0;
        for (int i = 0; i < 128; i++) begin
            golden[i] = {4'hF, 44'h0};
        end
        $readmemh("rv_exec_golden.txt", golden);
        if (golden[0][47:44] == 4'hF) begin
            $display("the golden file rv_exec_golden.txt is missing or empty");
            abort_run();
        end
        repeat (3) @(posedge CLK);
        RST <= 1'b0;
        check_reset_regs();
        play_golden();
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        repeat (2) @(posedge CLK);
        if (rv_exec_top_i.rv_exec_checker_i.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("bound assertions failed %0d times",
                     rv_exec_top_i.rv_exec_checker_i.fail_count);
            abort_run();
        end
    end

endmodule

/* vlog.f */
rv_pkg.sv
rv_apb_regs.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_exec_top.sv
rv_exec_checker.sv
tb_rv_exec.sv
